// ==== filelist.f ====
+incdir+logic
logic/lsq_pkg.sv
logic/circular_queue.sv
logic/mem_align.sv
logic/phys_regfile.sv
logic/data_ram.sv
logic/load_store_queue.sv
logic/lsu_top.sv
tb/tb_clock.sv
tb/lsu_tb.sv

// ==== logic/circular_queue.sv ====
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module circular_queue #(
    parameter int DEPTH = `LSQ_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                pop,
    input  lsq_pkg::lsq_entry_t push_entry,
    output lsq_pkg::lsq_entry_t entries [DEPTH],
    input  lsq_pkg::lsq_entry_t update_entries [DEPTH],
    input  logic [DEPTH-1:0]    update_mask,
    output lsq_pkg::ptr_t       head,
    output lsq_pkg::ptr_t       tail,
    output logic                full
);

    localparam int IDX_W = $clog2(DEPTH);

    logic empty;

    assign empty = head == tail;
    // Same slot, different lap
    assign full = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (update_mask[i]) begin
                    entries[i] <= update_entries[i];
                end
            end
            // Pop and push override any write-back to the same slot
            if (pop) begin
                entries[head[IDX_W-1:0]].valid <= 1'b0;
                head <= head + 1'b1;
            end
            if (push) begin
                entries[tail[IDX_W-1:0]] <= push_entry;
                tail <= tail + 1'b1;
            end
        end
    end

    // Upstream gating keeps the queue within bounds
    assert property (@(posedge clk) disable iff (rst) !(push && full) && !(pop && empty));

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module data_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_addr,
    input  logic        mem_rd,
    input  logic [3:0]  mem_wmask,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_resp
);
    import lsq_pkg::*;

    localparam int ADDR_W = $clog2(`RAM_WORDS);
    localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

    mem_word_u         ram [`RAM_WORDS];
    mem_word_u         wr_word;
    logic [ADDR_W-1:0] index;
    logic [CNT_W-1:0]  count;
    logic              pending;
    logic              done;

    assign wr_word = mem_wdata;
    assign index = mem_addr[ADDR_W+1:2];
    assign pending = mem_rd || (mem_wmask != 4'b0);
    // Last waiting cycle of the current request
    assign done = pending && !mem_resp && (count == CNT_W'(`RAM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            mem_resp <= 1'b0;
        end else begin
            mem_resp <= done;
            if (mem_resp || !pending) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            mem_rdata <= ram[index].word;
            for (int i = 0; i < 4; i++) begin
                if (mem_wmask[i]) begin
                    ram[index].bytes[i] <= wr_word.bytes[i];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) mem_resp |-> pending);

endmodule

// ==== logic/load_store_queue.sv ====
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module load_store_queue (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  lsq_pkg::dispatch_t dispatch,
    output logic               dispatch_ready,
    input  lsq_pkg::cdb_t      cdb_in,
    input  logic               commit_store,
    output lsq_pkg::preg_req_t preg_req,
    input  lsq_pkg::preg_rsp_t preg_rsp,
    output logic [31:0]        mem_addr,
    output logic               mem_rd,
    output logic [3:0]         mem_wmask,
    output logic [31:0]        mem_wdata,
    input  logic [31:0]        mem_rdata,
    input  logic               mem_resp,
    output lsq_pkg::cdb_t      lsq_cdb
);
    import lsq_pkg::*;

    lsq_entry_t            ld_entries [`LSQ_DEPTH];
    lsq_entry_t            st_entries [`LSQ_DEPTH];
    lsq_entry_t            ld_update [`LSQ_DEPTH];
    lsq_entry_t            st_update [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] ld_mask;
    logic [`LSQ_DEPTH-1:0] st_mask;
    ptr_t                  ld_head;
    ptr_t                  ld_tail;
    ptr_t                  st_head;
    ptr_t                  st_tail;
    logic                  ld_full;
    logic                  st_full;
    logic                  push_ld;
    logic                  push_st;
    lsq_entry_t            new_entry;
    lsq_entry_t            ld_push_entry;
    lsq_entry_t            st_push_entry;
    lsq_entry_t            ld_oldest;
    lsq_entry_t            st_oldest;
    lsq_entry_t            issue_entry;
    logic                  ld_ready;
    logic                  st_ready;
    logic                  waiting;
    logic                  issue_ld;
    logic                  issue_st;
    lsq_state_t            state;
    lsq_state_t            next_state;
    logic [31:0]           issue_addr;
    logic [31:0]           issue_wdata;
    logic [3:0]            issue_wmask;
    logic [31:0]           load_value;

    // Access in flight
    dispatch_t             acc_q;
    logic [31:0]           addr_q;
    logic [31:0]           wdata_q;
    logic [3:0]            wmask_q;
    logic [31:0]           result_q;

    function automatic logic tag_hit(input cdb_t c, input tag_t tag);
        return c.valid && !c.store_done && (c.rd == tag);
    endfunction

    function automatic lsq_entry_t wake(input lsq_entry_t e, input ptr_t other_head,
                                        input cdb_t a, input cdb_t b);
        lsq_entry_t w;
        w = e;
        if (tag_hit(a, e.d.rs1) || tag_hit(b, e.d.rs1)) begin
            w.rs1_ready = 1'b1;
        end
        if (tag_hit(a, e.d.rs2) || tag_hit(b, e.d.rs2)) begin
            w.rs2_ready = 1'b1;
        end
        // All older accesses of the other kind have left
        if (e.order_ptr == other_head) begin
            w.order_met = 1'b1;
        end
        return w;
    endfunction

    function automatic logic can_issue(input lsq_entry_t e, input ptr_t other_head);
        return e.valid && e.rs1_ready && e.rs2_ready
            && (e.order_met || (e.order_ptr == other_head));
    endfunction

    assign dispatch_ready = dispatch.op.is_store ? !st_full : !ld_full;
    assign push_ld = dispatch.valid && dispatch_ready && !dispatch.op.is_store;
    assign push_st = dispatch.valid && dispatch_ready && dispatch.op.is_store;

    always_comb begin
        new_entry.d = dispatch;
        new_entry.rs1_ready = dispatch.rs1 == '0;
        // Loads have no data operand
        new_entry.rs2_ready = !dispatch.op.is_store || (dispatch.rs2 == '0);
        new_entry.order_ptr = dispatch.op.is_store ? ld_tail : st_tail;
        new_entry.order_met = 1'b0;
        new_entry.valid = 1'b1;
    end

    assign ld_push_entry = wake(new_entry, st_head, cdb_in, lsq_cdb);
    assign st_push_entry = wake(new_entry, ld_head, cdb_in, lsq_cdb);

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            ld_update[i] = wake(ld_entries[i], st_head, cdb_in, lsq_cdb);
            st_update[i] = wake(st_entries[i], ld_head, cdb_in, lsq_cdb);
            ld_mask[i] = ld_entries[i].valid;
            st_mask[i] = st_entries[i].valid;
        end
    end

    circular_queue #(.DEPTH(`LSQ_DEPTH)) i_load_queue (
        .clk(clk),
        .rst(rst || flush),
        .push(push_ld),
        .pop(issue_ld),
        .push_entry(ld_push_entry),
        .entries(ld_entries),
        .update_entries(ld_update),
        .update_mask(ld_mask),
        .head(ld_head),
        .tail(ld_tail),
        .full(ld_full)
    );

    circular_queue #(.DEPTH(`LSQ_DEPTH)) i_store_queue (
        .clk(clk),
        .rst(rst || flush),
        .push(push_st),
        .pop(issue_st),
        .push_entry(st_push_entry),
        .entries(st_entries),
        .update_entries(st_update),
        .update_mask(st_mask),
        .head(st_head),
        .tail(st_tail),
        .full(st_full)
    );

    assign ld_oldest = ld_entries[ld_head[LSQ_IDX_W-1:0]];
    assign st_oldest = st_entries[st_head[LSQ_IDX_W-1:0]];
    assign ld_ready = can_issue(ld_oldest, st_head);
    assign st_ready = can_issue(st_oldest, ld_head) && commit_store;

    // Priority alternates with the wait state
    assign waiting = (state == wait_load_first) || (state == wait_store_first);
    assign issue_ld = !flush && waiting && ld_ready && (state == wait_load_first || !st_ready);
    assign issue_st = !flush && waiting && st_ready && (state == wait_store_first || !ld_ready);

    assign issue_entry = issue_st ? st_oldest : ld_oldest;
    assign preg_req.rs1 = issue_entry.d.rs1;
    assign preg_req.rs2 = issue_entry.d.rs2;
    assign issue_addr = preg_rsp.rs1_val + {{20{issue_entry.d.imm[11]}}, issue_entry.d.imm};

    mem_align i_issue_align (
        .op(issue_entry.d.op),
        .byte_offset(issue_addr[1:0]),
        .store_data(preg_rsp.rs2_val),
        .load_word(32'b0),
        .wmask(issue_wmask),
        .wdata(issue_wdata),
        .load_value()
    );

    mem_align i_load_align (
        .op(acc_q.op),
        .byte_offset(addr_q[1:0]),
        .store_data(32'b0),
        .load_word(mem_rdata),
        .wmask(),
        .wdata(),
        .load_value(load_value)
    );

    always_comb begin
        next_state = state;
        case (state)
            wait_load_first, wait_store_first: begin
                if (issue_ld) begin
                    next_state = request_load;
                end else if (issue_st) begin
                    next_state = request_store;
                end
            end
            request_load: begin
                if (mem_resp) begin
                    next_state = latch_load;
                end
            end
            request_store: begin
                if (mem_resp) begin
                    next_state = latch_store;
                end
            end
            latch_load: next_state = wait_store_first;
            default: next_state = wait_load_first;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wait_load_first;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ld || issue_st) begin
            acc_q <= issue_entry.d;
            addr_q <= issue_addr;
            wmask_q <= issue_wmask;
            wdata_q <= issue_wdata;
        end
        if (mem_resp && state == request_load) begin
            result_q <= load_value;
        end
    end

    assign mem_addr = addr_q;
    assign mem_rd = state == request_load;
    assign mem_wmask = (state == request_store) ? wmask_q : 4'b0;
    assign mem_wdata = wdata_q;

    always_comb begin
        lsq_cdb = '0;
        if (state == latch_load || state == latch_store) begin
            lsq_cdb.valid = 1'b1;
            lsq_cdb.rob_id = acc_q.rob_id;
            lsq_cdb.store_done = state == latch_store;
        end
        if (state == latch_load) begin
            lsq_cdb.rd = acc_q.rd;
            lsq_cdb.value = result_q;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_rd && (mem_wmask != 4'b0)));

endmodule

// ==== logic/lsq_cfg.svh ====
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Entries in each of the load and store queues
`define LSQ_DEPTH 8

// Physical register file
`define PREG_COUNT 64
`define TAG_W 6

// Data RAM size in 32-bit words
`define RAM_WORDS 256

// Cycles from the first request cycle to the response pulse
`define RAM_LATENCY 2

`endif

// ==== logic/lsq_pkg.sv ====
`include "lsq_cfg.svh"

package lsq_pkg;

    localparam int LSQ_IDX_W = $clog2(`LSQ_DEPTH);

    // Queue index plus wrap bit
    typedef logic [LSQ_IDX_W:0] ptr_t;
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [4:0] rob_id_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    typedef struct packed {
        logic      is_store;
        mem_size_t size;
        logic      is_unsigned;
    } mem_op_t;

    typedef struct packed {
        logic               valid;
        mem_op_t            op;
        tag_t               rd;
        tag_t               rs1;
        tag_t               rs2;
        logic signed [11:0] imm;
        rob_id_t            rob_id;
    } dispatch_t;

    typedef struct packed {
        dispatch_t d;
        logic      rs1_ready;
        logic      rs2_ready;
        // Other queue's tail when this entry was dispatched
        ptr_t      order_ptr;
        logic      order_met;
        logic      valid;
    } lsq_entry_t;

    typedef struct packed {
        logic        valid;
        tag_t        rd;
        logic [31:0] value;
        rob_id_t     rob_id;
        logic        store_done;
    } cdb_t;

    typedef struct packed {
        tag_t rs1;
        tag_t rs2;
    } preg_req_t;

    typedef struct packed {
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } preg_rsp_t;

    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

    typedef enum logic [2:0] {
        wait_load_first,
        wait_store_first,
        request_load,
        request_store,
        latch_load,
        latch_store
    } lsq_state_t;

endpackage

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  lsq_pkg::dispatch_t dispatch,
    output logic               dispatch_ready,
    input  lsq_pkg::cdb_t      cdb_in,
    input  logic               commit_store,
    output lsq_pkg::cdb_t      cdb_out
);
    import lsq_pkg::*;

    preg_req_t   preg_req;
    preg_rsp_t   preg_rsp;
    cdb_t        lsq_cdb;
    cdb_t        rf_wr;
    logic [31:0] mem_addr;
    logic        mem_rd;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_resp;

    // Load results win the write port
    assign rf_wr = lsq_cdb.valid ? lsq_cdb : cdb_in;
    assign cdb_out = lsq_cdb;

    load_store_queue i_lsq (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .dispatch(dispatch),
        .dispatch_ready(dispatch_ready),
        .cdb_in(cdb_in),
        .commit_store(commit_store),
        .preg_req(preg_req),
        .preg_rsp(preg_rsp),
        .mem_addr(mem_addr),
        .mem_rd(mem_rd),
        .mem_wmask(mem_wmask),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp),
        .lsq_cdb(lsq_cdb)
    );

    phys_regfile i_regfile (
        .clk(clk),
        .rst(rst),
        .req(preg_req),
        .rsp(preg_rsp),
        .wr_cdb(rf_wr)
    );

    data_ram i_ram (
        .clk(clk),
        .rst(rst),
        .mem_addr(mem_addr),
        .mem_rd(mem_rd),
        .mem_wmask(mem_wmask),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp)
    );

endmodule

// ==== logic/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
    input  lsq_pkg::mem_op_t op,
    input  logic [1:0]       byte_offset,
    input  logic [31:0]      store_data,
    input  logic [31:0]      load_word,
    output logic [3:0]       wmask,
    output logic [31:0]      wdata,
    output logic [31:0]      load_value
);
    import lsq_pkg::*;

    mem_word_u   word;
    logic [3:0]  base_mask;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign word = load_word;
    assign lane_b = word.bytes[byte_offset];
    assign lane_h = word.halves[byte_offset[1]];

    // Store side lanes
    assign wmask = base_mask << byte_offset;
    assign wdata = store_data << {byte_offset, 3'b000};

    always_comb begin
        case (op.size)
            size_byte: begin
                base_mask = 4'b0001;
                load_value = op.is_unsigned ? {24'b0, lane_b} : {{24{lane_b[7]}}, lane_b};
            end
            size_half: begin
                base_mask = 4'b0011;
                load_value = op.is_unsigned ? {16'b0, lane_h} : {{16{lane_h[15]}}, lane_h};
            end
            default: begin
                base_mask = 4'b1111;
                load_value = word.word;
            end
        endcase
    end

endmodule

// ==== logic/phys_regfile.sv ====
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module phys_regfile (
    input  logic               clk,
    input  logic               rst,
    input  lsq_pkg::preg_req_t req,
    output lsq_pkg::preg_rsp_t rsp,
    input  lsq_pkg::cdb_t      wr_cdb
);

    logic [31:0] regs [`PREG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_cdb.valid && !wr_cdb.store_done) begin
            regs[wr_cdb.rd] <= wr_cdb.value;
        end
    end

    // Tag 0 is the zero register
    assign rsp.rs1_val = (req.rs1 == '0) ? 32'b0 : regs[req.rs1];
    assign rsp.rs2_val = (req.rs2 == '0) ? 32'b0 : regs[req.rs2];

endmodule

// ==== tb/lsu_golden.txt ====
# name, actions, end; hex numbers. disp op rd rs1 rs2 imm rob, bcast tag value, expect rob value,
# commit level, quiet cycles, ready level, flush. op: lb 0 lbu 1 lh 2 lhu 3 lw 4 sb 8 sh a sw c
word_store_load disp c 00 00 10 100 01 expect 02 deadbeef disp 4 11 00 00 100 02
    bcast 10 deadbeef quiet 8 commit 1 end
byte_half_ext disp c 00 00 12 200 03 bcast 12 85f17f82
    expect 04 ffffff82 disp 0 20 00 00 200 04 expect 05 00000082 disp 1 20 00 00 200 05
    expect 06 0000007f disp 0 20 00 00 201 06 expect 07 0000007f disp 1 20 00 00 201 07
    expect 08 fffffff1 disp 0 20 00 00 202 08 expect 09 000000f1 disp 1 20 00 00 202 09
    expect 0a ffffff85 disp 0 20 00 00 203 0a expect 0b 00000085 disp 1 20 00 00 203 0b
    expect 0c 00007f82 disp 2 20 00 00 200 0c expect 0d 00007f82 disp 3 20 00 00 200 0d
    expect 0e ffff85f1 disp 2 20 00 00 202 0e expect 0f 000085f1 disp 3 20 00 00 202 0f end
late_base expect 10 deadbeef disp 4 21 30 00 ffc 10 quiet 10 bcast 30 00000104 end
byte_store_lane disp 8 00 00 14 201 11 bcast 14 123456aa
    expect 12 85f1aa82 disp 4 22 00 00 200 12 end
queue_full
    expect 13 deadbeef disp 4 23 31 00 000 13 expect 14 00000082 disp 1 23 31 00 100 14
    expect 15 000000aa disp 1 23 31 00 101 15 expect 16 fffffff1 disp 0 23 31 00 102 16
    expect 17 00000085 disp 1 23 31 00 103 17 expect 18 000085f1 disp 3 23 31 00 102 18
    expect 19 ffffaa82 disp 2 23 31 00 100 19 expect 1a 85f1aa82 disp 4 23 31 00 100 1a
    ready 0 quiet 4 bcast 31 00000100 end
flush_discard disp 4 24 32 00 000 1b disp 4 24 32 00 004 1c disp 4 24 32 00 008 1d
    quiet 4 flush quiet 4 bcast 32 00000100 quiet 10 ready 1
    expect 1e deadbeef disp 4 25 00 00 100 1e end

// ==== tb/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;
    import lsq_pkg::*;

    logic        clk;
    logic        rst;
    logic        flush;
    dispatch_t   dispatch;
    logic        dispatch_ready;
    cdb_t        cdb_in;
    logic        commit_store;
    cdb_t        cdb_out;

    string       tokens [$];
    // ROB ids in dispatch order, each removed when its result shows up
    int          order_q [$];
    logic [31:0] exp_val [int];
    // Dispatched instruction per ROB id
    dispatch_t   sent [int];
    string       test_name;
    int          errors;
    int          test_errors;
    int          tests;
    int          failed;
    int          n_actions;
    integer      seed;

    tb_clock i_clock (
        .clk(clk)
    );

    lsu_top i_dut (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .dispatch(dispatch),
        .dispatch_ready(dispatch_ready),
        .cdb_in(cdb_in),
        .commit_store(commit_store),
        .cdb_out(cdb_out)
    );

    function automatic logic is_action(input string t);
        return t == "disp" || t == "bcast" || t == "expect" || t == "commit"
            || t == "quiet" || t == "ready" || t == "flush";
    endfunction

    function automatic string next_token();
        return (tokens.size() != 0) ? tokens.pop_front() : "end";
    endfunction

    function automatic logic [31:0] next_hex();
        string t;
        t = (tokens.size() != 0) ? tokens.pop_front() : "0";
        return t.atohex();
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic load_golden();
        int    fd;
        string tok;
        string rest;
        fd = $fopen("tb/lsu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/lsu_golden.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                void'($fgets(rest, fd));
            end else begin
                tokens.push_back(tok);
                if (is_action(tok)) begin
                    n_actions++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_action(input string act);
        dispatch_t   d;
        logic [31:0] a;
        logic [31:0] b;
        if (act == "disp") begin
            d = '0;
            a = next_hex();
            d.op = mem_op_t'(a[3:0]);
            a = next_hex();
            d.rd = tag_t'(a);
            a = next_hex();
            d.rs1 = tag_t'(a);
            a = next_hex();
            d.rs2 = tag_t'(a);
            a = next_hex();
            d.imm = a[11:0];
            a = next_hex();
            d.rob_id = rob_id_t'(a);
            d.valid = 1'b1;
            @(negedge clk);
            dispatch = d;
            #1;
            // Held until the queue has room
            while (!dispatch_ready) begin
                @(negedge clk);
                #1;
            end
            order_q.push_back(d.rob_id);
            sent[int'(d.rob_id)] = d;
            @(negedge clk);
            dispatch.valid = 1'b0;
        end else if (act == "bcast") begin
            a = next_hex();
            b = next_hex();
            @(negedge clk);
            // Stay off the register write port while a load result is out
            while (cdb_out.valid) begin
                @(negedge clk);
            end
            cdb_in = '0;
            cdb_in.valid = 1'b1;
            cdb_in.rd = tag_t'(a);
            cdb_in.value = b;
            @(negedge clk);
            cdb_in = '0;
        end else if (act == "expect") begin
            a = next_hex();
            b = next_hex();
            exp_val[int'(a)] = b;
        end else if (act == "commit") begin
            a = next_hex();
            @(negedge clk);
            commit_store = a[0];
        end else if (act == "flush") begin
            @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            #1;
            order_q.delete();
        end else if (act == "quiet") begin
            a = next_hex();
            repeat (a) begin
                @(negedge clk);
                if (cdb_out.valid) begin
                    $display("unexpected CDB result during quiet wait in test %s", test_name);
                    note_error();
                end
            end
        end else if (act == "ready") begin
            a = next_hex();
            @(negedge clk);
            dispatch = '0;
            #1;
            if (dispatch_ready !== a[0]) begin
                $display("[FAIL] %s dispatch_ready expected %0d actual %0d",
                         test_name, a[0], dispatch_ready);
                note_error();
            end
        end else begin
            $display("unknown action %s in test %s", act, test_name);
            note_error();
        end
    endtask

    // Results must follow program order and match the golden values
    always @(negedge clk) begin
        int rob;
        if (!rst && cdb_out.valid) begin
            rob = cdb_out.rob_id;
            if (order_q.size() == 0) begin
                $display("unexpected CDB result for rob %0d in test %s", rob, test_name);
                note_error();
            end else begin
                if (order_q[0] != rob) begin
                    $display("[FAIL] %s order expected rob %0d actual rob %0d",
                             test_name, order_q[0], rob);
                    note_error();
                end
                void'(order_q.pop_front());
            end
            if (sent.exists(rob) && cdb_out.store_done !== sent[rob].op.is_store) begin
                $display("[FAIL] %s rob %0d store_done expected %0d actual %0d",
                         test_name, rob, sent[rob].op.is_store, cdb_out.store_done);
                note_error();
            end
            if (!cdb_out.store_done) begin
                if (!exp_val.exists(rob)) begin
                    $display("load result for rob %0d has no expected value", rob);
                    note_error();
                end else if (cdb_out.value !== exp_val[rob]) begin
                    $display("[FAIL] %s rob %0d expected %h actual %h",
                             test_name, rob, exp_val[rob], cdb_out.value);
                    note_error();
                end
                if (sent.exists(rob) && cdb_out.rd !== sent[rob].rd) begin
                    $display("[FAIL] %s rob %0d rd expected %h actual %h",
                             test_name, rob, sent[rob].rd, cdb_out.rd);
                    note_error();
                end
            end
        end
    end

    initial begin
        string act;
        int    idle;
        seed = 32'h1926;
        rst = 1'b1;
        flush = 1'b0;
        dispatch = '0;
        cdb_in = '0;
        commit_store = 1'b0;
        errors = 0;
        test_errors = 0;
        tests = 0;
        failed = 0;
        n_actions = 0;
        test_name = "reset";
        load_golden();
        fork
            begin
                #((n_actions * 20 + 10) * 100);
                $display("watchdog expired before all tests finished");
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (dispatch_ready !== 1'b1 || cdb_out.valid !== 1'b0) begin
            $display("outputs not idle after reset");
            errors++;
        end
        while (tokens.size() != 0) begin
            test_name = tokens.pop_front();
            test_errors = 0;
            act = next_token();
            while (act != "end") begin
                run_action(act);
                idle = $unsigned($random(seed)) % 3;
                repeat (idle) @(negedge clk);
                act = next_token();
            end
            // Wait for every accepted access to report
            while (order_q.size() != 0) begin
                @(posedge clk);
            end
            tests++;
            if (test_errors != 0) begin
                failed++;
            end
            $display("test %s: %0d errors", test_name, test_errors);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule
